// ==== common/tracerPkg.sv ====
package tracerPkg;

  // Q12.12 fixed point split used throughout the tracer
  localparam int FRAC_BITS = 12;
  localparam int INT_BITS = 12;

  // Signed value for positions, directions and reciprocals
  typedef logic signed [INT_BITS+FRAC_BITS-1:0] fixed_t;
  // Unsigned value for track distances, which may grow past the signed range
  typedef logic [INT_BITS+FRAC_BITS-1:0] ufixed_t;
  // Full width signed product of two fixed_t values
  typedef logic signed [2*(INT_BITS+FRAC_BITS)-1:0] wide_t;

  // Largest positive fixed_t, returned when the reciprocal saturates
  localparam fixed_t FIXED_MAX = {1'b0, {(INT_BITS+FRAC_BITS-1){1'b1}}};
  // The value 1.0 in Q12.12
  localparam fixed_t FIXED_ONE = fixed_t'(1) <<< FRAC_BITS;

  // The map is 16 cells by 16 cells
  localparam int MAP_COL_BITS = 4;
  localparam int MAP_ROW_BITS = 4;

  // Deflection is held at full vplane scale and shifted down when added to facing
  localparam int ADDEND_SHIFT = 8;
  // First traced line sits this many vplane steps above the screen centre
  localparam int START_LINES = 272;

  // Wall distance window is UQ7.9
  localparam int WALL_DIST_BITS = 16;
  // Wall half-size result width
  localparam int SIZE_BITS = 11;

  typedef struct packed {
    fixed_t x;
    fixed_t y;
  } vec_t;

  // View vectors, presented as plain inputs every cycle
  typedef struct packed {
    vec_t player;
    vec_t facing;
    vec_t vplane;
  } viewCfg_t;

  typedef struct packed {
    logic                 side;
    logic [SIZE_BITS-1:0] size;
  } traceResult_t;

  // Operand sources for the shared reciprocal
  typedef enum logic [1:0] {
    RCP_RAY_X,
    RCP_RAY_Y,
    RCP_WALL_DIST
  } rcpSrc_e;

  typedef enum logic [3:0] {
    SDX_PREP, SDX_WAIT, SDX_LOAD,
    SDY_PREP, SDY_WAIT, SDY_LOAD,
    INIT_X, INIT_Y,
    TRACE_STEP, TRACE_HIT,
    SIZE_PREP, SIZE_WAIT, SIZE_LOAD,
    TRACE_DONE
  } traceState_e;

endpackage

// ==== hw/reciprocal.sv ====
`timescale 1ns/10ps

module reciprocal (
  input  logic                                    clk,
  input  logic                                    i_load,
  input  tracerPkg::rcpSrc_e                      i_src,
  input  tracerPkg::vec_t                         i_rayDir,
  input  logic [tracerPkg::WALL_DIST_BITS-1:0]    i_wallDist,
  output tracerPkg::fixed_t                       o_recip
);
  import tracerPkg::*;

  fixed_t                          srcVal;
  ufixed_t                         opMag;
  ufixed_t                         divisor;
  logic [INT_BITS+FRAC_BITS:0]     quotient;

  // Pick the source and take its magnitude
  always_comb begin
    case (i_src)
      RCP_RAY_Y:     srcVal = i_rayDir.y;
      // The UQ7.9 window sits three bits up to land at Q12.12 weight
      RCP_WALL_DIST: srcVal = fixed_t'(ufixed_t'(i_wallDist) << 3);
      default:       srcVal = i_rayDir.x;
    endcase
  end

  // Operand register, loaded once per reciprocal request
  always_ff @(posedge clk) begin
    if (i_load) begin
      opMag <= (srcVal < 0) ? ufixed_t'(-srcVal) : ufixed_t'(srcVal);
    end
  end

  // 1/v in Q12.12 is 2^24 divided by the raw magnitude
  // A zero divisor is swapped for one, so its quotient overflows and saturates
  assign divisor = (opMag == '0) ? ufixed_t'(1) : opMag;
  assign quotient = ((INT_BITS+FRAC_BITS+1)'(1) << (2*FRAC_BITS)) / divisor;

  // Result is registered so it is valid two cycles after the load
  always_ff @(posedge clk) begin
    if (quotient > FIXED_MAX) begin
      o_recip <= FIXED_MAX;
    end else begin
      o_recip <= fixed_t'(quotient);
    end
  end

endmodule

// ==== hw/rayDirGen.sv ====
`timescale 1ns/10ps

module rayDirGen (
  input  logic                clk,
  input  logic                do_reset,
  input  logic                i_vsync,
  input  logic                i_nextLine,
  input  tracerPkg::viewCfg_t i_view,
  output tracerPkg::vec_t     o_rayDir
);
  import tracerPkg::*;

  // Deflection from the facing vector, kept at full vplane scale
  vec_t addend;
  // Deflection value for the top traced line of a frame
  vec_t startAddend;

  // Minus vplane times the start line count, truncated to Q12.12
  assign startAddend.x = fixed_t'(-(i_view.vplane.x * START_LINES));
  assign startAddend.y = fixed_t'(-(i_view.vplane.y * START_LINES));

  // Every new frame restarts the deflection at the top line
  // Each line end moves it down by one vplane step
  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      addend <= startAddend;
    end else if (i_nextLine) begin
      addend.x <= addend.x + i_view.vplane.x;
      addend.y <= addend.y + i_view.vplane.y;
    end
  end

  // Accumulating a whole vplane per line keeps precision
  // The arithmetic shift brings it back to a small fraction of vplane
  // Changing the shift amount changes the field of view
  assign o_rayDir.x = i_view.facing.x + (addend.x >>> ADDEND_SHIFT);
  assign o_rayDir.y = i_view.facing.y + (addend.y >>> ADDEND_SHIFT);

endmodule

// ==== tracer/gridWalker.sv ====
`timescale 1ns/10ps

module gridWalker (
  input  logic                                  clk,
  input  logic                                  do_reset,
  input  logic                                  i_vsync,
  input  tracerPkg::viewCfg_t                   i_view,
  input  tracerPkg::vec_t                       i_rayDir,
  input  tracerPkg::fixed_t                     i_recip,
  input  logic                                  i_loadStepX,
  input  logic                                  i_loadStepY,
  input  logic                                  i_initX,
  input  logic                                  i_initY,
  input  logic                                  i_step,
  output logic [tracerPkg::MAP_COL_BITS-1:0]    o_mapCol,
  output logic [tracerPkg::MAP_ROW_BITS-1:0]    o_mapRow,
  output logic [tracerPkg::WALL_DIST_BITS-1:0]  o_wallDist,
  output logic                                  o_side
);
  import tracerPkg::*;

  // Distance along the ray to cross one whole cell in each axis
  fixed_t  stepDistX;
  fixed_t  stepDistY;
  // Distance travelled to the next X and Y gridline crossing
  // These are unsigned so a huge step distance that wraps still compares correctly
  ufixed_t trackX;
  ufixed_t trackY;

  logic    rayPosX;
  logic    rayPosY;
  fixed_t  partialX;
  fixed_t  partialY;
  fixed_t  mulA;
  fixed_t  mulB;
  wide_t   mulOut;
  ufixed_t trackInit;
  logic    needStepX;

  // Ray direction sign decides which way the map cell walks
  assign rayPosX = i_rayDir.x > 0;
  assign rayPosY = i_rayDir.y > 0;

  // Portion of a cell between the player and the first gridline the ray meets
  // A zero fraction gives a full cell when walking up and nothing when walking down
  assign partialX = rayPosX ? FIXED_ONE - fixed_t'(i_view.player.x[FRAC_BITS-1:0])
                            : fixed_t'(i_view.player.x[FRAC_BITS-1:0]);
  assign partialY = rayPosY ? FIXED_ONE - fixed_t'(i_view.player.y[FRAC_BITS-1:0])
                            : fixed_t'(i_view.player.y[FRAC_BITS-1:0]);

  // One multiplier serves both init cycles
  assign mulA = i_initX ? stepDistX : stepDistY;
  assign mulB = i_initX ? partialX : partialY;
  assign mulOut = mulA * mulB;
  // Middle bits of the product are the Q12.12 result
  assign trackInit = ufixed_t'(mulOut[FRAC_BITS +: INT_BITS+FRAC_BITS]);

  // Step along whichever axis has the nearer gridline
  assign needStepX = trackX < trackY;

  // Step distances come straight off the shared reciprocal
  always_ff @(posedge clk) begin
    if (i_loadStepX) begin
      stepDistX <= i_recip;
    end
    if (i_loadStepY) begin
      stepDistY <= i_recip;
    end
  end

  // Map cell and track distances
  always_ff @(posedge clk) begin
    if (i_initX) begin
      // Start from the cell the player stands in
      o_mapCol <= i_view.player.x[FRAC_BITS +: MAP_COL_BITS];
      o_mapRow <= i_view.player.y[FRAC_BITS +: MAP_ROW_BITS];
      trackX <= trackInit;
    end else if (i_initY) begin
      trackY <= trackInit;
    end else if (i_step) begin
      if (needStepX) begin
        o_mapCol <= rayPosX ? o_mapCol + 1'b1 : o_mapCol - 1'b1;
        trackX <= trackX + ufixed_t'(stepDistX);
      end else begin
        o_mapRow <= rayPosY ? o_mapRow + 1'b1 : o_mapRow - 1'b1;
        trackY <= trackY + ufixed_t'(stepDistY);
      end
    end
  end

  // Wall distance is the track value before the step that reached the wall
  // Only the UQ7.9 window is kept, so fraction is cut to 9 bits and integer wraps at 128
  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      o_wallDist <= '0;
      o_side <= 1'b0;
    end else if (i_step) begin
      if (needStepX) begin
        o_wallDist <= trackX[FRAC_BITS+6 -: WALL_DIST_BITS];
        o_side <= 1'b0;
      end else begin
        o_wallDist <= trackY[FRAC_BITS+6 -: WALL_DIST_BITS];
        o_side <= 1'b1;
      end
    end
  end

endmodule

// ==== tracer/traceControl.sv ====
`timescale 1ns/10ps

module traceControl (
  input  logic                    clk,
  input  logic                    do_reset,
  input  logic                    i_vsync,
  input  logic                    i_hMax,
  input  logic                    i_mapVal,
  input  tracerPkg::fixed_t       i_recip,
  input  logic                    i_side,
  output logic                    o_rcpLoad,
  output tracerPkg::rcpSrc_e      o_rcpSrc,
  output logic                    o_loadStepX,
  output logic                    o_loadStepY,
  output logic                    o_initX,
  output logic                    o_initY,
  output logic                    o_step,
  output logic                    o_nextLine,
  output tracerPkg::traceResult_t o_result
);
  import tracerPkg::*;

  traceState_e state;
  traceState_e nextState;

  // Next state logic
  // Each reciprocal request takes a prep, a wait and a load cycle
  always_comb begin
    nextState = state;
    case (state)
      SDX_PREP:   nextState = SDX_WAIT;
      SDX_WAIT:   nextState = SDX_LOAD;
      SDX_LOAD:   nextState = SDY_PREP;
      SDY_PREP:   nextState = SDY_WAIT;
      SDY_WAIT:   nextState = SDY_LOAD;
      SDY_LOAD:   nextState = INIT_X;
      INIT_X:     nextState = INIT_Y;
      INIT_Y:     nextState = TRACE_STEP;
      // Keep stepping through empty cells until the current one is a wall
      TRACE_STEP: begin
        if (i_mapVal) begin
          nextState = TRACE_HIT;
        end
      end
      TRACE_HIT:  nextState = SIZE_PREP;
      SIZE_PREP:  nextState = SIZE_WAIT;
      SIZE_WAIT:  nextState = SIZE_LOAD;
      SIZE_LOAD:  nextState = TRACE_DONE;
      // Wait here for the end of the display line
      TRACE_DONE: begin
        if (i_hMax) begin
          nextState = SDX_PREP;
        end
      end
      default:    nextState = SDX_PREP;
    endcase
  end

  // A new frame holds the tracer at the start of the first line
  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      state <= SDX_PREP;
    end else begin
      state <= nextState;
    end
  end

  // Reciprocal requests for both step distances and the wall size
  assign o_rcpLoad = (state == SDX_PREP) || (state == SDY_PREP) || (state == SIZE_PREP);

  always_comb begin
    case (state)
      SDY_PREP:  o_rcpSrc = RCP_RAY_Y;
      SIZE_PREP: o_rcpSrc = RCP_WALL_DIST;
      default:   o_rcpSrc = RCP_RAY_X;
    endcase
  end

  // Datapath strobes, one cycle each
  assign o_loadStepX = state == SDX_LOAD;
  assign o_loadStepY = state == SDY_LOAD;
  assign o_initX = state == INIT_X;
  assign o_initY = state == INIT_Y;
  // The map ROM answers in the same cycle, so an empty cell steps at once
  assign o_step = (state == TRACE_STEP) && !i_mapVal;
  // Line end advances the ray to the next line
  assign o_nextLine = (state == TRACE_DONE) && i_hMax;

  // Result is shown on the line after it was traced
  // Size takes reciprocal bits 2 down to -8 of the wall distance
  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      o_result <= '0;
    end else if (o_nextLine) begin
      o_result.size <= i_recip[FRAC_BITS+2 -: SIZE_BITS];
      o_result.side <= i_side;
    end
  end

endmodule

// ==== hw/wallTracer.sv ====
`timescale 1ns/10ps

module wallTracer (
  input  logic                                clk,
  input  logic                                do_reset,
  input  logic                                i_vsync,
  input  logic                                i_hMax,
  input  tracerPkg::viewCfg_t                 i_view,
  input  logic                                i_mapVal,
  output logic [tracerPkg::MAP_COL_BITS-1:0]  o_mapCol,
  output logic [tracerPkg::MAP_ROW_BITS-1:0]  o_mapRow,
  output tracerPkg::traceResult_t             o_result
);
  import tracerPkg::*;

  // Control strobes from the sequencer
  logic                      rcpLoad;
  rcpSrc_e                   rcpSrc;
  logic                      loadStepX;
  logic                      loadStepY;
  logic                      initX;
  logic                      initY;
  logic                      step;
  logic                      nextLine;

  // Datapath values
  vec_t                      rayDir;
  fixed_t                    recip;
  logic [WALL_DIST_BITS-1:0] wallDist;
  logic                      side;

  // Line sequencer, which also holds the presented result
  traceControl uControl (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_vsync     (i_vsync),
    .i_hMax      (i_hMax),
    .i_mapVal    (i_mapVal),
    .i_recip     (recip),
    .i_side      (side),
    .o_rcpLoad   (rcpLoad),
    .o_rcpSrc    (rcpSrc),
    .o_loadStepX (loadStepX),
    .o_loadStepY (loadStepY),
    .o_initX     (initX),
    .o_initY     (initY),
    .o_step      (step),
    .o_nextLine  (nextLine),
    .o_result    (o_result)
  );

  rayDirGen uRayDir (
    .clk        (clk),
    .do_reset   (do_reset),
    .i_vsync    (i_vsync),
    .i_nextLine (nextLine),
    .i_view     (i_view),
    .o_rayDir   (rayDir)
  );

  // Single reciprocal shared by both step distances and the wall size
  reciprocal uRecip (
    .clk        (clk),
    .i_load     (rcpLoad),
    .i_src      (rcpSrc),
    .i_rayDir   (rayDir),
    .i_wallDist (wallDist),
    .o_recip    (recip)
  );

  gridWalker uWalker (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_vsync     (i_vsync),
    .i_view      (i_view),
    .i_rayDir    (rayDir),
    .i_recip     (recip),
    .i_loadStepX (loadStepX),
    .i_loadStepY (loadStepY),
    .i_initX     (initX),
    .i_initY     (initY),
    .i_step      (step),
    .o_mapCol    (o_mapCol),
    .o_mapRow    (o_mapRow),
    .o_wallDist  (wallDist),
    .o_side      (side)
  );

endmodule

// ==== tests/tracerModel.svh ====
`ifndef TRACER_MODEL_SVH
`define TRACER_MODEL_SVH

// Magnitude of a signed Q12.12 value as a plain integer
function automatic longint fixedMagnitude(input fixed_t value);
  return (value < 0) ? -longint'(value) : longint'(value);
endfunction

// One over a raw Q12.12 magnitude, clipped to the largest positive fixed value
function automatic longint saturatingRecip(input longint magnitude);
  longint limit;
  longint quotient;
  limit = (longint'(1) << (INT_BITS + FRAC_BITS - 1)) - 1;
  if (magnitude == 0) begin
    return limit;
  end
  quotient = (longint'(1) << (2 * FRAC_BITS)) / magnitude;
  return (quotient > limit) ? limit : quotient;
endfunction

// Ray component for a given line of the frame
// Line 0 sits START_LINES vplane steps above centre
function automatic fixed_t rayComponent(input fixed_t facing, input fixed_t vplane,
                                        input int line);
  fixed_t deflection;
  deflection = fixed_t'((line - START_LINES) * int'(vplane));
  return fixed_t'(facing + (deflection >>> ADDEND_SHIFT));
endfunction

// Keep 9 fraction bits and let the integer part wrap at 128
function automatic longint wallWindow(input longint track);
  return (track >> (FRAC_BITS - 9)) & ((longint'(1) << WALL_DIST_BITS) - 1);
endfunction

// Full line trace from the view and line number
// The wall cell where the walk stopped comes back through hitCol and hitRow
function automatic traceResult_t traceLine(input viewCfg_t view, input int line,
                                           output int hitCol, output int hitRow);
  fixed_t       rayX;
  fixed_t       rayY;
  longint       stepX;
  longint       stepY;
  longint       trackX;
  longint       trackY;
  longint       trackMask;
  longint       window;
  int           col;
  int           row;
  int           dirX;
  int           dirY;
  int           fracX;
  int           fracY;
  int           steps;
  logic         hitSide;
  traceResult_t res;
  trackMask = (longint'(1) << (INT_BITS + FRAC_BITS)) - 1;
  rayX = rayComponent(view.facing.x, view.vplane.x, line);
  rayY = rayComponent(view.facing.y, view.vplane.y, line);
  stepX = saturatingRecip(fixedMagnitude(rayX));
  stepY = saturatingRecip(fixedMagnitude(rayY));
  // A zero component walks toward lower cells
  dirX = (rayX > 0) ? 1 : -1;
  dirY = (rayY > 0) ? 1 : -1;
  fracX = int'(view.player.x[FRAC_BITS-1:0]);
  fracY = int'(view.player.y[FRAC_BITS-1:0]);
  trackX = (stepX * ((dirX > 0) ? (1 << FRAC_BITS) - fracX : fracX)) >> FRAC_BITS;
  trackY = (stepY * ((dirY > 0) ? (1 << FRAC_BITS) - fracY : fracY)) >> FRAC_BITS;
  col = int'(view.player.x[FRAC_BITS +: MAP_COL_BITS]);
  row = int'(view.player.y[FRAC_BITS +: MAP_ROW_BITS]);
  window = 0;
  hitSide = 1'b0;
  steps = 0;
  // The nearer gridline wins and ties go to Y
  while (!wallAt(col, row) && steps < 64) begin
    if (trackX < trackY) begin
      window = wallWindow(trackX);
      hitSide = 1'b0;
      col = (col + dirX) & ((1 << MAP_COL_BITS) - 1);
      trackX = (trackX + stepX) & trackMask;
    end else begin
      window = wallWindow(trackY);
      hitSide = 1'b1;
      row = (row + dirY) & ((1 << MAP_ROW_BITS) - 1);
      trackY = (trackY + stepY) & trackMask;
    end
    steps++;
  end
  hitCol = col;
  hitRow = row;
  res.side = hitSide;
  // Window goes back to Q12.12 weight and the size keeps bits 2 down to -8
  res.size = SIZE_BITS'(saturatingRecip(window << (FRAC_BITS - 9)) >> 4);
  return res;
endfunction

`endif

// ==== tests/wallTracerTb.sv ====
`timescale 1ns/10ps

module wallTracerTb;
  import tracerPkg::*;

  localparam int LINES = 12;
  localparam int LINE_CYCLES = 64;
  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_VIEWS = 3;
  // Two axis frames plus each random view traced twice
  localparam int FRAMES = 2 + 2 * RANDOM_VIEWS;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + FRAMES * (LINES * LINE_CYCLES + 4) + 200;

  logic                    clk;
  logic                    do_reset;
  logic                    vsync;
  logic                    hMax;
  viewCfg_t                view;
  logic                    mapVal;
  logic [MAP_COL_BITS-1:0] mapCol;
  logic [MAP_ROW_BITS-1:0] mapRow;
  traceResult_t            result;

  int           errorCount = 0;
  int           checkCount = 0;
  int           cycleCount = 0;
  int unsigned  lcgState = 81;
  logic         freshFrame = 1'b0;
  traceResult_t lineResults [LINES];
  traceResult_t firstRun [LINES];

  // Map ROM with a border ring and a few interior blocks
  function automatic logic wallAt(input int col, input int row);
    if (col == 0 || col == 15 || row == 0 || row == 15) begin
      return 1'b1;
    end
    if (col >= 5 && col <= 6 && row >= 4 && row <= 5) begin
      return 1'b1;
    end
    if (col == 10 && row >= 8 && row <= 11) begin
      return 1'b1;
    end
    return (col == 3 && row == 11) || (col == 12 && row == 3);
  endfunction

  `include "tracerModel.svh"

  wallTracer u_dut (
    .clk      (clk),
    .do_reset (do_reset),
    .i_vsync  (vsync),
    .i_hMax   (hMax),
    .i_view   (view),
    .i_mapVal (mapVal),
    .o_mapCol (mapCol),
    .o_mapRow (mapRow),
    .o_result (result)
  );

  // The ROM answers in the same cycle as the address
  assign mapVal = wallAt(int'(mapCol), int'(mapRow));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int unsigned nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState >> 8;
  endfunction

  // Straight along X or Y with no vplane, so every line is the same
  // Nonzero fractions keep the idle axis far from its first gridline
  function automatic viewCfg_t axisView(input logic alongY);
    viewCfg_t v;
    v = '0;
    v.player.x = fixed_t'(alongY ? 7 * 4096 + 2048 : 2 * 4096 + 1024);
    v.player.y = fixed_t'(alongY ? 2 * 4096 + 1024 : 7 * 4096 + 2048);
    v.facing.x = alongY ? fixed_t'(0) : FIXED_ONE;
    v.facing.y = alongY ? FIXED_ONE : fixed_t'(0);
    return v;
  endfunction

  function automatic viewCfg_t randomView();
    viewCfg_t v;
    int       col;
    int       row;
    col = 0;
    row = 0;
    // Redraw until the player stands in an open cell
    while (wallAt(col, row)) begin
      col = 1 + int'(nextRandom() % 14);
      row = 1 + int'(nextRandom() % 14);
    end
    v.player.x = fixed_t'((col << FRAC_BITS) + int'(nextRandom() % 4096));
    v.player.y = fixed_t'((row << FRAC_BITS) + int'(nextRandom() % 4096));
    v.facing.x = fixed_t'(int'(nextRandom() % 8193) - 4096);
    v.facing.y = fixed_t'(int'(nextRandom() % 8193) - 4096);
    v.vplane.x = fixed_t'(int'(nextRandom() % 4097) - 2048);
    v.vplane.y = fixed_t'(int'(nextRandom() % 4097) - 2048);
    return v;
  endfunction

  // New view and a one cycle vsync pulse
  task automatic startFrame(input viewCfg_t v);
    @(posedge clk);
    view <= v;
    vsync <= 1'b1;
    @(posedge clk);
    vsync <= 1'b0;
    freshFrame = 1'b1;
  endtask

  // One hMax per line, then the presented result is checked against the model
  task automatic runLines(input viewCfg_t v, input logic checkSide, input logic expectSide);
    traceResult_t expected;
    int           expectedCol;
    int           expectedRow;
    for (int n = 0; n < LINES; n++) begin
      repeat (LINE_CYCLES - 1) @(posedge clk);
      hMax <= 1'b1;
      @(posedge clk);
      hMax <= 1'b0;
      freshFrame = 1'b0;
      @(negedge clk);
      expected = traceLine(v, n, expectedCol, expectedRow);
      lineResults[n] = result;
      checkCount++;
      lineMatch: assert (result == expected) else begin
        errorCount++;
        $display("error %0t: line %0d gave size %0d side %0b, expected size %0d side %0b",
                 $time, n, result.size, result.side, expected.size, expected.side);
      end
      // The map address stays on the wall cell until the next line loads the player cell
      checkCount++;
      hitCell: assert (int'(mapCol) == expectedCol && int'(mapRow) == expectedRow) else begin
        errorCount++;
        $display("error %0t: line %0d stopped at cell %0d,%0d, expected cell %0d,%0d",
                 $time, n, mapCol, mapRow, expectedCol, expectedRow);
      end
      if (checkSide) begin
        checkCount++;
        axisSide: assert (result.side == expectSide) else begin
          errorCount++;
          $display("error %0t: line %0d side %0b on an axis view, expected %0b",
                   $time, n, result.side, expectSide);
        end
      end
    end
  endtask

  // Result stays cleared until the first line of a frame is presented
  always @(negedge clk) begin
    if (freshFrame) begin
      checkCount++;
      clearedAtFrameStart: assert (result == '0) else begin
        errorCount++;
        $display("error %0t: result %h before the first hMax of the frame", $time, result);
      end
    end
  end

  // Only an hMax, a vsync or a reset may change the presented result
  resultHolds: assert property (@(posedge clk) disable iff (do_reset)
    (!$past(hMax) && !$past(vsync) && !$past(do_reset)) |-> $stable(result))
    else begin
      errorCount++;
      $display("error %0t: result changed to %h without a preceding hMax", $time, result);
    end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    viewCfg_t randView;
    do_reset <= 1'b1;
    vsync <= 1'b0;
    hMax <= 1'b0;
    view <= axisView(1'b0);
    repeat (RESET_CYCLES) @(posedge clk);
    do_reset <= 1'b0;
    freshFrame = 1'b1;
    // First frame runs straight out of reset with no vsync
    runLines(axisView(1'b0), 1'b1, 1'b0);
    startFrame(axisView(1'b1));
    runLines(axisView(1'b1), 1'b1, 1'b1);
    // Each random view is traced twice to see the deflection restart
    for (int f = 0; f < RANDOM_VIEWS; f++) begin
      randView = randomView();
      startFrame(randView);
      runLines(randView, 1'b0, 1'b0);
      firstRun = lineResults;
      startFrame(randView);
      runLines(randView, 1'b0, 1'b0);
      for (int n = 0; n < LINES; n++) begin
        checkCount++;
        frameRepeats: assert (lineResults[n] == firstRun[n]) else begin
          errorCount++;
          $display("error %0t: view %0d line %0d gave %h after vsync, first pass gave %h",
                   $time, f, n, lineResults[n], firstRun[n]);
        end
      end
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+tests
common/tracerPkg.sv
hw/reciprocal.sv
hw/rayDirGen.sv
tracer/gridWalker.sv
tracer/traceControl.sv
hw/wallTracer.sv
tests/wallTracerTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module wallTracerTb \
  -f sim.f --Mdir obj_dir -o wallTracerSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/wallTracerSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0
